// ==== rtl/opl3_ctrl_pkg.sv ====
// shared widths, register map and types for the OPL3 operator slot controller
// every RTL file refers to these by scoped name
package opl3_ctrl_pkg;

    localparam int NUM_BANKS    = 2;
    localparam int OPS_PER_BANK = 18;
    localparam int NUM_SLOTS    = NUM_BANKS * OPS_PER_BANK;
    localparam int OP_MEM_DEPTH = 22;  // offsets 0x00..0x15, some unused
    localparam int CH_MEM_DEPTH = 9;

    typedef logic [7:0] reg_addr_t;
    typedef logic [7:0] reg_data_t;
    typedef logic       bank_t;
    typedef logic [4:0] op_num_t;
    typedef logic [4:0] op_addr_t;
    typedef logic [3:0] ch_addr_t;

    // per-operator groups
    localparam reg_addr_t BASE_AM_MULT   = 8'h20;
    localparam reg_addr_t BASE_KSL_TL    = 8'h40;
    localparam reg_addr_t BASE_AR_DR     = 8'h60;
    localparam reg_addr_t BASE_SL_RR     = 8'h80;
    localparam reg_addr_t BASE_WS        = 8'hE0;
    // per-channel groups
    localparam reg_addr_t BASE_FNUM_LOW  = 8'hA0;
    localparam reg_addr_t BASE_KON_BLOCK = 8'hB0;
    localparam reg_addr_t BASE_FB_CNT    = 8'hC0;

    typedef logic [3:0] mult_t;
    typedef logic [1:0] ksl_t;
    typedef logic [5:0] tl_t;
    typedef logic [3:0] env_t;       // ar, dr, sl, rr
    typedef logic [2:0] ws_t;
    typedef logic [9:0] fnum_t;
    typedef logic [2:0] block_t;
    typedef logic [2:0] fb_t;
    typedef logic [5:0] conn_sel_t;  // bank 0 in [2:0], bank 1 in [5:3]

    typedef enum logic [2:0] {
        OP_NORMAL,
        OP_BASS_DRUM,
        OP_HI_HAT,
        OP_TOM_TOM,
        OP_SNARE_DRUM,
        OP_TOP_CYMBAL
    } op_type_t;

    typedef enum logic {
        SEQ_IDLE,
        SEQ_SWEEP
    } seq_state_t;

endpackage

// ==== rtl/banked_ram.sv ====
// two-bank register memory, one write port and one registered read port
// contents clear on reset, read data holds while rd_en is low
`timescale 1ns/1ps

module banked_ram #(
    parameter int DATA_WIDTH = 8,
    parameter int DEPTH      = 22
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     wr_en,
    input  opl3_ctrl_pkg::bank_t     wr_bank,
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  logic [DATA_WIDTH-1:0]    wr_data,
    input  logic                     rd_en,
    input  opl3_ctrl_pkg::bank_t     rd_bank,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output logic [DATA_WIDTH-1:0]    rd_data
);

    logic [DATA_WIDTH-1:0] mem [opl3_ctrl_pkg::NUM_BANKS][DEPTH];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem     <= '{default: '0};
            rd_data <= '0;
        end else begin
            if (wr_en)
                mem[wr_bank][wr_addr] <= wr_data;
            if (rd_en)
                rd_data <= mem[rd_bank][rd_addr];  // new write seen one cycle on
        end
    end

endmodule

// ==== rtl/slot_sequencer.sv ====
// walks the 36 operator slots once per sample_clk_en
// also gives the one-cycle delayed slot id that goes out with the read data
`timescale 1ns/1ps

module slot_sequencer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   sample_clk_en,
    output logic                   slot_active,
    output opl3_ctrl_pkg::bank_t   slot_bank,
    output opl3_ctrl_pkg::op_num_t slot_op,
    output logic                   slot_valid,
    output opl3_ctrl_pkg::bank_t   valid_bank,
    output opl3_ctrl_pkg::op_num_t valid_op,
    output logic                   sweep_done
);

    opl3_ctrl_pkg::seq_state_t state;
    logic [5:0] slot_cnt;
    logic       valid_d;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= opl3_ctrl_pkg::SEQ_IDLE;
            slot_cnt <= '0;
        end else begin
            case (state)
                opl3_ctrl_pkg::SEQ_IDLE: begin
                    slot_cnt <= '0;
                    if (sample_clk_en)
                        state <= opl3_ctrl_pkg::SEQ_SWEEP;
                end
                opl3_ctrl_pkg::SEQ_SWEEP: begin  // sample_clk_en ignored here
                    if (slot_cnt == 6'(opl3_ctrl_pkg::NUM_SLOTS - 1)) begin
                        state    <= opl3_ctrl_pkg::SEQ_IDLE;
                        slot_cnt <= '0;
                    end else begin
                        slot_cnt <= slot_cnt + 6'd1;
                    end
                end
                default: state <= opl3_ctrl_pkg::SEQ_IDLE;
            endcase
        end
    end

    assign slot_active = (state == opl3_ctrl_pkg::SEQ_SWEEP);
    assign slot_bank   = (slot_cnt >= 6'(opl3_ctrl_pkg::OPS_PER_BANK));
    assign slot_op     = opl3_ctrl_pkg::op_num_t'(slot_bank ?
                         slot_cnt - 6'(opl3_ctrl_pkg::OPS_PER_BANK) : slot_cnt);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot_valid <= 1'b0;
            valid_d    <= 1'b0;
            sweep_done <= 1'b0;
        end else begin
            slot_valid <= slot_active;
            valid_d    <= slot_valid;
            sweep_done <= valid_d && !slot_valid;  // one cycle after valid drops
        end
    end

    // slot id lined up with the registered read data
    always_ff @(posedge clk) begin
        valid_bank <= slot_bank;
        valid_op   <= slot_op;
    end

endmodule

// ==== rtl/operator_reg_file.sv ====
// write decode and storage for the five per-operator register groups
// read side is addressed by the mapped operator address of the current slot
`timescale 1ns/1ps

module operator_reg_file (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     reg_wr_valid,
    input  opl3_ctrl_pkg::bank_t     reg_wr_bank,
    input  opl3_ctrl_pkg::reg_addr_t reg_wr_addr,
    input  opl3_ctrl_pkg::reg_data_t reg_wr_data,
    input  logic                     rd_en,
    input  opl3_ctrl_pkg::bank_t     rd_bank,
    input  opl3_ctrl_pkg::op_addr_t  op_rd_addr,
    output logic                     am,
    output logic                     vib,
    output logic                     egt,
    output logic                     ksr,
    output opl3_ctrl_pkg::mult_t     mult,
    output opl3_ctrl_pkg::ksl_t      ksl,
    output opl3_ctrl_pkg::tl_t       tl,
    output opl3_ctrl_pkg::env_t      ar,
    output opl3_ctrl_pkg::env_t      dr,
    output opl3_ctrl_pkg::env_t      sl,
    output opl3_ctrl_pkg::env_t      rr,
    output opl3_ctrl_pkg::ws_t       ws
);

    // full byte groups, in order am/mult, ksl/tl, ar/dr, sl/rr
    localparam opl3_ctrl_pkg::reg_addr_t GRP_BASE [4] = '{
        opl3_ctrl_pkg::BASE_AM_MULT,
        opl3_ctrl_pkg::BASE_KSL_TL,
        opl3_ctrl_pkg::BASE_AR_DR,
        opl3_ctrl_pkg::BASE_SL_RR
    };

    opl3_ctrl_pkg::reg_data_t grp_word [4];
    opl3_ctrl_pkg::reg_addr_t ws_off;

    for (genvar g = 0; g < 4; g++) begin : g_grp
        opl3_ctrl_pkg::reg_addr_t off;

        assign off = reg_wr_addr - GRP_BASE[g];  // below base wraps high, so misses

        banked_ram #(
            .DATA_WIDTH($bits(opl3_ctrl_pkg::reg_data_t)),
            .DEPTH     (opl3_ctrl_pkg::OP_MEM_DEPTH)
        ) u_mem (
            .clk     (clk),
            .rst_n   (rst_n),
            .wr_en   (reg_wr_valid && off < 8'(opl3_ctrl_pkg::OP_MEM_DEPTH)),
            .wr_bank (reg_wr_bank),
            .wr_addr (opl3_ctrl_pkg::op_addr_t'(off)),
            .wr_data (reg_wr_data),
            .rd_en   (rd_en),
            .rd_bank (rd_bank),
            .rd_addr (op_rd_addr),
            .rd_data (grp_word[g])
        );
    end

    assign ws_off = reg_wr_addr - opl3_ctrl_pkg::BASE_WS;

    banked_ram #(
        .DATA_WIDTH($bits(opl3_ctrl_pkg::ws_t)),
        .DEPTH     (opl3_ctrl_pkg::OP_MEM_DEPTH)
    ) u_ws_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (reg_wr_valid && ws_off < 8'(opl3_ctrl_pkg::OP_MEM_DEPTH)),
        .wr_bank (reg_wr_bank),
        .wr_addr (opl3_ctrl_pkg::op_addr_t'(ws_off)),
        .wr_data (reg_wr_data[2:0]),
        .rd_en   (rd_en),
        .rd_bank (rd_bank),
        .rd_addr (op_rd_addr),
        .rd_data (ws)
    );

    assign {am, vib, egt, ksr, mult} = grp_word[0];
    assign {ksl, tl}                 = grp_word[1];
    assign {ar, dr}                  = grp_word[2];
    assign {sl, rr}                  = grp_word[3];

endmodule

// ==== rtl/channel_reg_file.sv ====
// write decode and storage for the three per-channel register groups
// fnum and kon/block share the four-op substituted channel, fb/cnt does not
`timescale 1ns/1ps

module channel_reg_file (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     reg_wr_valid,
    input  opl3_ctrl_pkg::bank_t     reg_wr_bank,
    input  opl3_ctrl_pkg::reg_addr_t reg_wr_addr,
    input  opl3_ctrl_pkg::reg_data_t reg_wr_data,
    input  logic                     rd_en,
    input  opl3_ctrl_pkg::bank_t     rd_bank,
    input  opl3_ctrl_pkg::ch_addr_t  ch_fnum_addr,
    input  opl3_ctrl_pkg::ch_addr_t  ch_fb_addr,
    output opl3_ctrl_pkg::fnum_t     fnum,
    output opl3_ctrl_pkg::block_t    block,
    output logic                     kon,
    output opl3_ctrl_pkg::fb_t       fb,
    output logic                     cnt
);

    opl3_ctrl_pkg::reg_addr_t fnum_off;
    opl3_ctrl_pkg::reg_addr_t kon_off;
    opl3_ctrl_pkg::reg_addr_t fb_off;
    logic [5:0]               kon_word;  // kon, block, fnum[9:8]
    logic [3:0]               fb_word;   // fb, cnt

    assign fnum_off = reg_wr_addr - opl3_ctrl_pkg::BASE_FNUM_LOW;
    assign kon_off  = reg_wr_addr - opl3_ctrl_pkg::BASE_KON_BLOCK;
    assign fb_off   = reg_wr_addr - opl3_ctrl_pkg::BASE_FB_CNT;

    banked_ram #(.DATA_WIDTH(8), .DEPTH(opl3_ctrl_pkg::CH_MEM_DEPTH)) u_fnum_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (reg_wr_valid && fnum_off < 8'(opl3_ctrl_pkg::CH_MEM_DEPTH)),
        .wr_bank (reg_wr_bank),
        .wr_addr (opl3_ctrl_pkg::ch_addr_t'(fnum_off)),
        .wr_data (reg_wr_data),
        .rd_en   (rd_en),
        .rd_bank (rd_bank),
        .rd_addr (ch_fnum_addr),
        .rd_data (fnum[7:0])
    );

    banked_ram #(.DATA_WIDTH(6), .DEPTH(opl3_ctrl_pkg::CH_MEM_DEPTH)) u_kon_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (reg_wr_valid && kon_off < 8'(opl3_ctrl_pkg::CH_MEM_DEPTH)),
        .wr_bank (reg_wr_bank),
        .wr_addr (opl3_ctrl_pkg::ch_addr_t'(kon_off)),
        .wr_data (reg_wr_data[5:0]),
        .rd_en   (rd_en),
        .rd_bank (rd_bank),
        .rd_addr (ch_fnum_addr),  // same channel as fnum low
        .rd_data (kon_word)
    );

    banked_ram #(.DATA_WIDTH(4), .DEPTH(opl3_ctrl_pkg::CH_MEM_DEPTH)) u_fb_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (reg_wr_valid && fb_off < 8'(opl3_ctrl_pkg::CH_MEM_DEPTH)),
        .wr_bank (reg_wr_bank),
        .wr_addr (opl3_ctrl_pkg::ch_addr_t'(fb_off)),
        .wr_data (reg_wr_data[3:0]),
        .rd_en   (rd_en),
        .rd_bank (rd_bank),
        .rd_addr (ch_fb_addr),
        .rd_data (fb_word)
    );

    assign {kon, block, fnum[9:8]} = kon_word;
    assign {fb, cnt}               = fb_word;

endmodule

// ==== rtl/slot_routing.sv ====
// maps the current slot to memory addresses and works out the routing flags
// flags are registered so they line up with the register file read data
`timescale 1ns/1ps

module slot_routing (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     slot_active,
    input  opl3_ctrl_pkg::bank_t     slot_bank,
    input  opl3_ctrl_pkg::op_num_t   slot_op,
    input  opl3_ctrl_pkg::conn_sel_t connection_sel,
    input  logic                     ryt,
    input  logic                     cnt,
    output opl3_ctrl_pkg::op_addr_t  op_rd_addr,
    output opl3_ctrl_pkg::ch_addr_t  ch_fnum_addr,
    output opl3_ctrl_pkg::ch_addr_t  ch_fb_addr,
    output logic                     use_feedback,
    output logic                     mod_enable,
    output opl3_ctrl_pkg::op_type_t  op_type
);

    logic [1:0]              grp;       // which group of six operators
    logic [2:0]              grp_op;
    logic [1:0]              op_mod3;
    logic                    conn_bit;  // four-op bit for this channel pair
    logic                    rhythm;
    logic                    fb_next;
    logic                    mod_next;
    logic                    mod_cand;
    opl3_ctrl_pkg::op_type_t type_next;

    always_comb begin
        if (slot_op < 5'd6)
            grp = 2'd0;
        else if (slot_op < 5'd12)
            grp = 2'd1;
        else
            grp = 2'd2;
        grp_op   = 3'(slot_op - 5'(grp) * 5'd6);
        op_mod3  = (grp_op >= 3'd3) ? 2'(grp_op - 3'd3) : grp_op[1:0];
        conn_bit = slot_bank ? connection_sel[3'd3 + 3'(op_mod3)] : connection_sel[op_mod3];
        rhythm   = ryt && !slot_bank;

        op_rd_addr   = opl3_ctrl_pkg::op_addr_t'(slot_op + 5'({grp, 1'b0}));
        ch_fb_addr   = opl3_ctrl_pkg::ch_addr_t'(4'(grp) * 4'd3 + 4'(op_mod3));
        ch_fnum_addr = (grp == 2'd1 && conn_bit) ? 4'(op_mod3) : ch_fb_addr;
    end

    always_comb begin
        fb_next   = 1'b0;
        mod_next  = 1'b0;
        type_next = opl3_ctrl_pkg::OP_NORMAL;
        case (slot_op)
            5'd0, 5'd1, 5'd2, 5'd12:                   fb_next = 1'b1;
            5'd3, 5'd4, 5'd5, 5'd9, 5'd10, 5'd11, 5'd15: mod_next = 1'b1;
            5'd6, 5'd7, 5'd8: begin  // second half of a four-op pair when set
                fb_next  = !conn_bit;
                mod_next = conn_bit;
            end
            5'd13, 5'd14:                              fb_next = !rhythm;
            5'd16, 5'd17:                              mod_next = !rhythm;
            default: ;
        endcase
        if (rhythm) begin
            case (slot_op)
                5'd12, 5'd15: type_next = opl3_ctrl_pkg::OP_BASS_DRUM;
                5'd13:        type_next = opl3_ctrl_pkg::OP_HI_HAT;
                5'd14:        type_next = opl3_ctrl_pkg::OP_TOM_TOM;
                5'd16:        type_next = opl3_ctrl_pkg::OP_SNARE_DRUM;
                5'd17:        type_next = opl3_ctrl_pkg::OP_TOP_CYMBAL;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            use_feedback <= 1'b0;
            mod_cand     <= 1'b0;
            op_type      <= opl3_ctrl_pkg::OP_NORMAL;
        end else begin
            use_feedback <= slot_active && fb_next;
            mod_cand     <= slot_active && mod_next;
            op_type      <= slot_active ? type_next : opl3_ctrl_pkg::OP_NORMAL;
        end
    end

    // cnt arrives with the read data, same cycle as the registered candidacy
    assign mod_enable = mod_cand && !cnt;

endmodule

// ==== rtl/opl3_slot_ctrl.sv ====
// top of the operator time-slot controller
// register writes go in on the strobe, one sweep of 36 slots per sample_clk_en
`timescale 1ns/1ps

module opl3_slot_ctrl (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     sample_clk_en,
    input  logic                     reg_wr_valid,
    input  opl3_ctrl_pkg::bank_t     reg_wr_bank,
    input  opl3_ctrl_pkg::reg_addr_t reg_wr_addr,
    input  opl3_ctrl_pkg::reg_data_t reg_wr_data,
    input  opl3_ctrl_pkg::conn_sel_t connection_sel,
    input  logic                     ryt,
    output logic                     slot_valid,
    output opl3_ctrl_pkg::bank_t     slot_bank,
    output opl3_ctrl_pkg::op_num_t   slot_op,
    output logic                     am,
    output logic                     vib,
    output logic                     egt,
    output logic                     ksr,
    output opl3_ctrl_pkg::mult_t     mult,
    output opl3_ctrl_pkg::ksl_t      ksl,
    output opl3_ctrl_pkg::tl_t       tl,
    output opl3_ctrl_pkg::env_t      ar,
    output opl3_ctrl_pkg::env_t      dr,
    output opl3_ctrl_pkg::env_t      sl,
    output opl3_ctrl_pkg::env_t      rr,
    output opl3_ctrl_pkg::ws_t       ws,
    output opl3_ctrl_pkg::fnum_t     fnum,
    output opl3_ctrl_pkg::block_t    block,
    output logic                     kon,
    output opl3_ctrl_pkg::fb_t       fb,
    output logic                     cnt,
    output logic                     use_feedback,
    output logic                     mod_enable,
    output opl3_ctrl_pkg::op_type_t  op_type,
    output logic                     sweep_done
);

    logic                    seq_active;
    opl3_ctrl_pkg::bank_t    seq_bank;  // live slot, drives the read addresses
    opl3_ctrl_pkg::op_num_t  seq_op;
    opl3_ctrl_pkg::op_addr_t op_rd_addr;
    opl3_ctrl_pkg::ch_addr_t ch_fnum_addr;
    opl3_ctrl_pkg::ch_addr_t ch_fb_addr;

    slot_sequencer u_seq (
        .clk           (clk),
        .rst_n         (rst_n),
        .sample_clk_en (sample_clk_en),
        .slot_active   (seq_active),
        .slot_bank     (seq_bank),
        .slot_op       (seq_op),
        .slot_valid    (slot_valid),
        .valid_bank    (slot_bank),
        .valid_op      (slot_op),
        .sweep_done    (sweep_done)
    );

    operator_reg_file u_op_regs (
        .clk, .rst_n,
        .reg_wr_valid, .reg_wr_bank, .reg_wr_addr, .reg_wr_data,
        .rd_en   (seq_active),
        .rd_bank (seq_bank),
        .op_rd_addr,
        .am, .vib, .egt, .ksr, .mult, .ksl, .tl, .ar, .dr, .sl, .rr, .ws
    );

    channel_reg_file u_ch_regs (
        .clk, .rst_n,
        .reg_wr_valid, .reg_wr_bank, .reg_wr_addr, .reg_wr_data,
        .rd_en   (seq_active),
        .rd_bank (seq_bank),
        .ch_fnum_addr, .ch_fb_addr,
        .fnum, .block, .kon, .fb, .cnt
    );

    slot_routing u_route (
        .clk, .rst_n,
        .slot_active (seq_active),
        .slot_bank   (seq_bank),
        .slot_op     (seq_op),
        .connection_sel, .ryt, .cnt,
        .op_rd_addr, .ch_fnum_addr, .ch_fb_addr,
        .use_feedback, .mod_enable, .op_type
    );

endmodule

// ==== dv/tb_opl3_slot_ctrl.sv ====
// testbench for the operator slot controller
// tests come from dv/slot_patterns.txt; a shadow of both register banks
// gives the expected value of every reported slot
`timescale 1ns/1ps

module tb_opl3_slot_ctrl;

    localparam int CLK_HALF  = 50;
    localparam int SWEEP_LEN = 45;  // negedges watched per sweep
    localparam int MID_PULSE = 12;  // sample_clk_en again, mid sweep

    logic        clk;
    logic        rst_n;
    logic        sample_clk_en;
    logic        reg_wr_valid;
    logic        reg_wr_bank;
    logic [7:0]  reg_wr_addr;
    logic [7:0]  reg_wr_data;
    logic [5:0]  connection_sel;
    logic        ryt;
    logic        slot_valid;
    logic        slot_bank;
    logic [4:0]  slot_op;
    logic        am, vib, egt, ksr;
    logic [3:0]  mult;
    logic [1:0]  ksl;
    logic [5:0]  tl;
    logic [3:0]  ar, dr, sl, rr;
    logic [2:0]  ws;
    logic [9:0]  fnum;
    logic [2:0]  block;
    logic        kon;
    logic [2:0]  fb;
    logic        cnt;
    logic        use_feedback;
    logic        mod_enable;
    logic [2:0]  op_type;
    logic        sweep_done;

    // test list and expanded writes, filled from the pattern file
    string t_name[$];
    int    t_ryt[$];
    int    t_conn[$];
    int    t_first[$];
    int    t_count[$];
    int    w_bank[$];
    int    w_addr[$];
    int    w_data[$];

    int          op_shadow[];  // [bank][group][offset], flattened
    int          ch_shadow[];
    logic [31:0] rng = 32'd40754;
    int          cycle_cnt = 0;
    int          cycle_limit = 100000;
    int          max_writes = 0;
    int          checks = 0;
    int          total_errors = 0;
    int          test_errs = 0;
    int          passed = 0;
    int          failed = 0;
    string       cur_test;
    string       where;

    opl3_slot_ctrl u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles", cycle_cnt);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int op_base(input int g);
        case (g)
            0:       return 'h20;
            1:       return 'h40;
            2:       return 'h60;
            3:       return 'h80;
            default: return 'he0;
        endcase
    endfunction

    function automatic int ch_base(input int g);
        case (g)
            0:       return 'ha0;
            1:       return 'hb0;
            default: return 'hc0;
        endcase
    endfunction

    function automatic int op_word(input int b, input int g, input int off);
        return op_shadow[(b * 5 + g) * 22 + off];
    endfunction

    function automatic int ch_word(input int b, input int g, input int off);
        return ch_shadow[(b * 3 + g) * 9 + off];
    endfunction

    task automatic check_val(input string sig, input int got, input int exp);
        checks++;
        if (got != exp) begin
            test_errs++;
            total_errors++;
            $display("ERROR %0s %0s: got 0x%0h expected 0x%0h", where, sig, got, exp);
        end
    endtask

    // register map decode, only the defined low bits are kept
    task automatic shadow_write(input int b, input int a, input int d);
        int g;
        int off;
        for (g = 0; g < 5; g++) begin
            off = a - op_base(g);
            if (off >= 0 && off < 22)
                op_shadow[(b * 5 + g) * 22 + off] = (g == 4) ? (d & 7) : d;
        end
        for (g = 0; g < 3; g++) begin
            off = a - ch_base(g);
            if (off >= 0 && off < 9)
                ch_shadow[(b * 3 + g) * 9 + off] = d & ((g == 0) ? 255 : (g == 1) ? 63 : 15);
        end
    endtask

    task automatic load_patterns(output bit ok);
        int               fd;
        int               code;
        int               ry;
        int               cn;
        int               nl;
        int               b;
        int               a;
        int               n;
        int               d;
        int               r;
        int               i;
        int               j;
        int               total;
        bit               bad;
        logic [127:0]     tok;
        logic [8*120-1:0] rest;
        ok  = 1'b0;
        bad = 1'b0;
        fd  = $fopen("dv/slot_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open dv/slot_patterns.txt for reading");
        end else begin
            code = $fscanf(fd, "%s", tok);
            while (code == 1 && !bad) begin
                if (tok == 128'("#")) begin
                    code = $fgets(rest, fd);  // comment line
                end else begin
                    code = $fscanf(fd, "%d %h %d", ry, cn, nl);
                    if (code != 3)
                        bad = 1'b1;
                    t_name.push_back($sformatf("%0s", tok));
                    t_ryt.push_back(ry);
                    t_conn.push_back(cn);
                    t_first.push_back(w_addr.size());
                    total = 0;
                    for (i = 0; i < nl && !bad; i++) begin
                        code = $fscanf(fd, "%d %h %d %h %d", b, a, n, d, r);
                        if (code != 5)
                            bad = 1'b1;
                        for (j = 0; j < n; j++) begin
                            if (r != 0)
                                rng = xorshift32(rng);
                            w_bank.push_back(b);
                            w_addr.push_back(a + j);
                            w_data.push_back((r != 0) ? int'(rng[7:0]) : d);
                        end
                        total += n;
                    end
                    t_count.push_back(total);
                    if (total > max_writes)
                        max_writes = total;
                end
                code = $fscanf(fd, "%s", tok);
            end
            $fclose(fd);
            if (bad)
                $display("pattern file has a malformed line near test %0s", tok);
            ok = !bad && t_name.size() > 0;
            cycle_limit = t_name.size() * 60 + max_writes * t_name.size() + 200;
        end
    endtask

    task automatic check_slot(input int s);
        int b;
        int o;
        int grp;
        int m3;
        int oa;
        int ch;
        int fch;
        int kw;
        int fw;
        int exp_type;
        bit conn;
        bit rhythm;
        bit exp_fb;
        bit exp_cand;
        b    = s / 18;
        o    = s % 18;
        grp  = o / 6;
        m3   = o % 3;
        oa   = o + 2 * grp;  // offsets 6,7 and 14,15 never read
        ch   = grp * 3 + m3;
        conn = ((int'(connection_sel) >> (b * 3 + m3)) & 1) == 1;
        fch  = (grp == 1 && conn) ? m3 : ch;  // four-op pair uses the first channel
        kw   = ch_word(b, 1, fch);
        fw   = ch_word(b, 2, ch);
        rhythm = ryt && b == 0;
        where = $sformatf("%0s bank %0d op %0d", cur_test, b, o);
        check_val("slot_bank", int'(slot_bank), b);
        check_val("slot_op", int'(slot_op), o);
        check_val("am", int'(am), op_word(b, 0, oa) >> 7);
        check_val("vib", int'(vib), (op_word(b, 0, oa) >> 6) & 1);
        check_val("egt", int'(egt), (op_word(b, 0, oa) >> 5) & 1);
        check_val("ksr", int'(ksr), (op_word(b, 0, oa) >> 4) & 1);
        check_val("mult", int'(mult), op_word(b, 0, oa) & 15);
        check_val("ksl", int'(ksl), op_word(b, 1, oa) >> 6);
        check_val("tl", int'(tl), op_word(b, 1, oa) & 63);
        check_val("ar", int'(ar), op_word(b, 2, oa) >> 4);
        check_val("dr", int'(dr), op_word(b, 2, oa) & 15);
        check_val("sl", int'(sl), op_word(b, 3, oa) >> 4);
        check_val("rr", int'(rr), op_word(b, 3, oa) & 15);
        check_val("ws", int'(ws), op_word(b, 4, oa));
        check_val("fnum", int'(fnum), ((kw & 3) << 8) | ch_word(b, 0, fch));
        check_val("block", int'(block), (kw >> 2) & 7);
        check_val("kon", int'(kon), kw >> 5);
        check_val("fb", int'(fb), fw >> 1);
        check_val("cnt", int'(cnt), fw & 1);
        exp_fb = o <= 2 || o == 12 || (o >= 6 && o <= 8 && !conn)
                 || ((o == 13 || o == 14) && !rhythm);
        exp_cand = (o >= 3 && o <= 5) || (o >= 9 && o <= 11) || o == 15
                   || (o >= 6 && o <= 8 && conn) || (o >= 16 && !rhythm);
        check_val("use_feedback", int'(use_feedback), int'(exp_fb));
        check_val("mod_enable", int'(mod_enable), int'(exp_cand && (fw & 1) == 0));
        exp_type = 0;
        if (rhythm) begin
            case (o)
                12, 15:  exp_type = 1;  // bass drum
                13:      exp_type = 2;
                14:      exp_type = 3;
                16:      exp_type = 4;
                17:      exp_type = 5;
                default: exp_type = 0;
            endcase
        end
        check_val("op_type", int'(op_type), exp_type);
    endtask

    // slot_valid from the 2nd negedge for 36, sweep_done at the 39th
    task automatic run_sweep();
        int k;
        @(negedge clk);
        reg_wr_valid  = 1'b0;
        sample_clk_en = 1'b1;
        for (k = 1; k <= SWEEP_LEN; k++) begin
            @(negedge clk);
            where = $sformatf("%0s sweep cycle %0d", cur_test, k);
            check_val("slot_valid", int'(slot_valid), (k >= 2 && k <= 37) ? 1 : 0);
            check_val("sweep_done", int'(sweep_done), (k == 39) ? 1 : 0);
            if (k >= 2 && k <= 37)
                check_slot(k - 2);
            sample_clk_en = (k == MID_PULSE) ? 1'b1 : 1'b0;
        end
    endtask

    task automatic finish_test();
        if (test_errs == 0)
            passed++;
        else
            failed++;
        $display("test %0s finished with %0d errors", cur_test, test_errs);
    endtask

    task automatic run_test(input int t);
        int i;
        cur_test  = t_name[t];
        test_errs = 0;
        @(negedge clk);
        ryt            = 1'(t_ryt[t]);
        connection_sel = 6'(t_conn[t]);
        for (i = t_first[t]; i < t_first[t] + t_count[t]; i++) begin
            @(negedge clk);
            reg_wr_valid = 1'b1;
            reg_wr_bank  = 1'(w_bank[i]);
            reg_wr_addr  = 8'(w_addr[i]);
            reg_wr_data  = 8'(w_data[i]);
            shadow_write(w_bank[i], w_addr[i], w_data[i]);
        end
        run_sweep();
        finish_test();
    endtask

    initial begin
        bit loaded;
        int t;
        int k;
        rst_n          = 1'b0;
        sample_clk_en  = 1'b0;
        reg_wr_valid   = 1'b0;
        reg_wr_bank    = 1'b0;
        reg_wr_addr    = 8'h00;
        reg_wr_data    = 8'h00;
        connection_sel = 6'h00;
        ryt            = 1'b0;
        op_shadow      = new[2 * 5 * 22];
        ch_shadow      = new[2 * 3 * 9];
        load_patterns(loaded);
        if (loaded) begin
            repeat (16) @(negedge clk);
            rst_n     = 1'b1;
            cur_test  = "idle_after_reset";
            test_errs = 0;
            for (k = 0; k < 4; k++) begin
                @(negedge clk);
                where = $sformatf("%0s cycle %0d", cur_test, k);
                check_val("slot_valid", int'(slot_valid), 0);
                check_val("sweep_done", int'(sweep_done), 0);
            end
            finish_test();
            for (t = 0; t < t_name.size(); t++)
                run_test(t);
        end
        $display("summary: %0d tests passed, %0d failed, %0d checks, %0d errors",
                 passed, failed, checks, total_errors);
        if (loaded && total_errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== dv/slot_patterns.txt ====
# test line: name ryt connection_sel(hex) write_lines
# write line: bank addr(hex) count data(hex) random, count writes from addr up, random 1 = xorshift
zero_sweep 0 00 0
op_groups 0 00 13
0 20 22 00 1
1 20 22 00 1
0 40 22 00 1
1 40 22 00 1
0 60 22 00 1
1 60 22 00 1
0 80 22 00 1
1 80 22 00 1
0 e0 22 00 1
1 e0 22 00 1
0 26 2 ff 0
0 36 10 ff 0
1 f6 10 ff 0
ch_conn_zero 0 00 8
0 a0 9 00 1
1 a0 9 00 1
0 b0 9 00 1
1 b0 9 00 1
0 c0 9 00 1
1 c0 9 00 1
0 a9 7 ff 0
1 b9 7 ff 0
ch_conn_mixed 0 25 0
ch_conn_all 0 3f 2
0 c0 9 0e 0
1 c0 9 0f 0
rhythm_b0 1 00 1
0 c0 9 00 1
rhythm_conn 1 3f 1
1 c0 5 0e 0
rhythm_off 0 12 2
0 b0 9 00 1
1 a0 3 00 1

// ==== all.f ====
rtl/opl3_ctrl_pkg.sv
rtl/banked_ram.sv
rtl/slot_sequencer.sv
rtl/operator_reg_file.sv
rtl/channel_reg_file.sv
rtl/slot_routing.sv
rtl/opl3_slot_ctrl.sv
dv/tb_opl3_slot_ctrl.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build with Verilator, run from the project root, then search the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps -f all.f \
    --top-module tb_opl3_slot_ctrl -o tb_sim > build.log 2>&1 &&
    ./obj_dir/tb_sim > sim.log 2>&1 ||
    echo "build or simulation did not complete, see build.log and sim.log"
grep -qx "RESULT: PASS" sim.log 2>/dev/null && echo "simulation passed" ||
    { echo "simulation failed"; exit 1; }
